// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbControlUnit
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tbModel.svh ====
`ifndef TBMODEL_SVH
`define TBMODEL_SVH

	//////////////////////////////////////////////////////////////////////
	// Reference model of the decode rules
	//////////////////////////////////////////////////////////////////////

	// First table entry whose fixed opcode bits agree, -1 if none
	function automatic int findEntry(input logic [10:0] op);
		for (int i = 0; i < numEntries; i++) begin
			if ((op & opMask[i]) == opValue[i])
				return i;
		end
		return -1;
	endfunction

	// Expected control word for one class
	function automatic logic [31:0] modelWord(input logic [31:0] instr, input int cls,
			input logic [4:0] func);
		logic [31:0] w;
		w = '0;
		w[31:30] = 2'b01;  // PC plus four
		w[14:10] = func;
		w[1] = 1'b1;       // sl on every class
		case (cls)
			clsAluReg, clsBranchReg: begin
				w[29:25] = instr[4:0];
				w[24:20] = instr[9:5];
				w[19:15] = instr[20:16];
				w[9] = (cls == clsAluReg);
				w[6] = 1'b1;
			end
			clsAluImm: begin
				w[29:25] = instr[4:0];
				w[24:20] = instr[9:5];
				w[9] = 1'b1;
				w[6] = 1'b1;
				w[3] = 1'b1;
			end
			clsLoad: begin
				w[29:25] = instr[4:0];
				w[24:20] = instr[9:5];
				w[9] = 1'b1;
				w[7] = 1'b1;  // enMem
				w[3] = 1'b1;
			end
			clsStore: begin
				w[29:25] = instr[4:0];
				w[24:20] = instr[9:5];
				w[8] = 1'b1;  // ramW
				w[6] = 1'b1;
				w[3] = 1'b1;
			end
			clsCbz, clsCbnz, clsBcond: begin
				w[29:25] = instr[4:0];
				w[6] = 1'b1;
				w[2] = 1'b1;  // pcSel
			end
			default: begin  // B and BL
				w[9] = (cls == clsBl);
				w[6] = 1'b1;
				w[2] = 1'b1;
			end
		endcase
		return w;
	endfunction

	// Expected constant, previous value where the class has none
	function automatic logic [63:0] modelConst(input logic [31:0] instr, input int cls,
			input logic [63:0] prev);
		case (cls)
			clsAluImm:                 return {52'b0, instr[21:10]};
			clsLoad, clsStore:         return {55'b0, instr[20:12]};
			clsCbz, clsCbnz, clsBcond: return {43'b0, instr[23:5], 2'b00};
			clsB, clsBl:               return {36'b0, instr[25:0], 2'b00};
			default:                   return prev;
		endcase
	endfunction

`endif

// ==== test/tbControlUnit.sv ====
`timescale 1ns/100ps

module tbControlUnit;

	localparam int numEntries = 32;
	localparam int numRandom = 100;
	localparam int numInstr = 5 + numEntries * 3 + numRandom + 4;

	// Model class codes
	localparam int clsAluReg = 0, clsAluImm = 1, clsLoad = 2, clsStore = 3;
	localparam int clsCbz = 4, clsCbnz = 5, clsBcond = 6;
	localparam int clsB = 7, clsBl = 8, clsBranchReg = 9;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic [31:0] instruction = '0;
	logic [31:0] controlWord;
	logic [63:0] constant;
	logic        flag;
	logic [2:0]  length;

	// Opcode table with fixed bits and mask per mnemonic
	logic [10:0] opValue [numEntries];
	logic [10:0] opMask [numEntries];
	int          opClass [numEntries];
	logic [4:0]  opFunc [numEntries];
	logic        opFlag [numEntries];
	logic [2:0]  opSize [numEntries];
	int          tableFill = 0;

	logic [31:0] expWord = '0;
	logic [63:0] expConst = '0;
	logic        expFlag = 1'b0;
	logic [2:0]  expLength = '0;
	logic [15:0] lfsr = 16'd26;
	int          errCount = 0;

	`include "tbModel.svh"

	controlUnit #(.DataWidth(64)) uut (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.controlWord (controlWord),
		.constant    (constant),
		.flag        (flag),
		.length      (length)
	);

	always #5 clk = ~clk;  // 10 ns period

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic addEntry(input logic [10:0] val, input logic [10:0] mask, input int cls,
			input logic [4:0] func, input logic setF, input logic [2:0] size);
		opValue[tableFill] = val;
		opMask[tableFill] = mask;
		opClass[tableFill] = cls;
		opFunc[tableFill] = func;
		opFlag[tableFill] = setF;
		opSize[tableFill] = size;
		tableFill++;
	endtask

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic randomBits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};  // One step per bit
		end
	endtask

	// Random instruction with the fixed opcode bits of an entry
	task automatic makeInstr(input int idx, output logic [31:0] v);
		logic [31:0] r;
		randomBits(32, r);
		v = r;
		v[31:21] = (r[31:21] & ~opMask[idx]) | opValue[idx];
	endtask

	task automatic apply(input logic [31:0] v);
		@(posedge clk);
		#1 instruction = v;  // Off the edge
	endtask

	task automatic applyUnknown();
		logic [31:0] r;
		randomBits(21, r);
		apply({11'b0, r[20:0]});  // Opcode 0 matches no rule
	endtask

	task automatic reportError(input string field, input logic [63:0] got,
			input logic [63:0] exp);
		$display("** Error at %0t: %s is %h, expected %h", $time, field, got, exp);
		errCount++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Model state one edge behind like the DUT
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		int idx;
		idx = findEntry(instruction[31:21]);
		if (rst) begin
			expWord = '0;
			expConst = '0;
			expFlag = 1'b0;
			expLength = '0;
		end else if (idx >= 0) begin  // Unknown opcode holds
			expWord = modelWord(instruction, opClass[idx], opFunc[idx]);
			expConst = modelConst(instruction, opClass[idx], expConst);
			expFlag = opFlag[idx];
			expLength = opSize[idx];
		end
	end

	// Compared mid-cycle where both sides are settled
	checkWord: assert property (@(negedge clk) controlWord == expWord)
		else reportError("controlWord", 64'(controlWord), 64'(expWord));
	checkConst: assert property (@(negedge clk) constant == expConst)
		else reportError("constant", constant, expConst);
	checkFlag: assert property (@(negedge clk) flag == expFlag)
		else reportError("flag", 64'(flag), 64'(expFlag));
	checkLength: assert property (@(negedge clk) length == expLength)
		else reportError("length", 64'(length), 64'(expLength));

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] v;
		logic [31:0] r;
		int idx;
		addEntry(11'b10001011000, 11'h7FF, clsAluReg, 5'b00010, 1'b0, 3'b010);  // ADD
		addEntry(11'b11001011000, 11'h7FF, clsAluReg, 5'b00110, 1'b0, 3'b010);  // SUB
		addEntry(11'b10101011000, 11'h7FF, clsAluReg, 5'b00010, 1'b1, 3'b010);  // ADDS
		addEntry(11'b11101011000, 11'h7FF, clsAluReg, 5'b00110, 1'b1, 3'b010);  // SUBS
		addEntry(11'b10001010000, 11'h7FF, clsAluReg, 5'b01100, 1'b0, 3'b010);  // AND
		addEntry(11'b10101010000, 11'h7FF, clsAluReg, 5'b01101, 1'b0, 3'b010);  // ORR
		addEntry(11'b11001010000, 11'h7FF, clsAluReg, 5'b01110, 1'b0, 3'b010);  // EOR
		addEntry(11'b11101010000, 11'h7FF, clsAluReg, 5'b01100, 1'b1, 3'b010);  // ANDS
		addEntry(11'b11010011010, 11'h7FF, clsAluReg, 5'b10000, 1'b0, 3'b010);  // LSR
		addEntry(11'b11010011011, 11'h7FF, clsAluReg, 5'b01111, 1'b0, 3'b010);  // LSL
		addEntry(11'b10010001000, 11'h7FE, clsAluImm, 5'b00010, 1'b0, 3'b010);  // ADDI
		addEntry(11'b11010001000, 11'h7FE, clsAluImm, 5'b00110, 1'b0, 3'b010);  // SUBI
		addEntry(11'b10110001000, 11'h7FE, clsAluImm, 5'b00010, 1'b1, 3'b010);  // ADDIS
		addEntry(11'b11110001000, 11'h7FE, clsAluImm, 5'b00110, 1'b1, 3'b010);  // SUBIS
		addEntry(11'b10010010000, 11'h7FE, clsAluImm, 5'b01100, 1'b0, 3'b010);  // ANDI
		addEntry(11'b10110010000, 11'h7FE, clsAluImm, 5'b01101, 1'b0, 3'b010);  // ORRI
		addEntry(11'b11010010000, 11'h7FE, clsAluImm, 5'b01110, 1'b0, 3'b010);  // EORI
		addEntry(11'b11110010000, 11'h7FE, clsAluImm, 5'b01100, 1'b1, 3'b010);  // ANDIS
		addEntry(11'b00111000010, 11'h7FF, clsLoad, 5'b00010, 1'b0, 3'b000);    // LDURB
		addEntry(11'b01111000010, 11'h7FF, clsLoad, 5'b00010, 1'b0, 3'b001);    // LDURH
		addEntry(11'b10111000010, 11'h7FF, clsLoad, 5'b00010, 1'b0, 3'b010);    // LDURW
		addEntry(11'b11111000010, 11'h7FF, clsLoad, 5'b00010, 1'b0, 3'b100);    // LDUR
		addEntry(11'b00111000000, 11'h7FF, clsStore, 5'b00010, 1'b0, 3'b000);   // STURB
		addEntry(11'b01111000000, 11'h7FF, clsStore, 5'b00010, 1'b0, 3'b001);   // STURH
		addEntry(11'b10111000000, 11'h7FF, clsStore, 5'b00010, 1'b0, 3'b010);   // STURW
		addEntry(11'b11111000000, 11'h7FF, clsStore, 5'b00010, 1'b0, 3'b100);   // STUR
		addEntry(11'b10110100000, 11'h7F8, clsCbz, 5'b01100, 1'b0, 3'b010);     // CBZ
		addEntry(11'b10110101000, 11'h7F8, clsCbnz, 5'b01100, 1'b0, 3'b010);    // CBNZ
		addEntry(11'b01010100000, 11'h7F8, clsBcond, 5'b01100, 1'b0, 3'b010);   // B.cond
		addEntry(11'b00010100000, 11'h7E0, clsB, 5'b01100, 1'b0, 3'b010);       // B
		addEntry(11'b10010100000, 11'h7E0, clsBl, 5'b01100, 1'b0, 3'b010);      // BL
		addEntry(11'b11010110000, 11'h7FF, clsBranchReg, 5'b01001, 1'b0, 3'b010); // BR

		repeat (3) @(posedge clk);  // Reset for 3 cycles
		#1 rst = 1'b0;
		applyUnknown();
		applyUnknown();
		@(negedge clk);
		assert (controlWord == 0 && constant == 0 && flag == 0 && length == 0)
			else reportError("outputs after reset", 64'(controlWord), 64'd0);

		// Every opcode once back to back
		for (int i = 0; i < numEntries; i++) begin
			makeInstr(i, v);
			apply(v);
		end

		// Unknown opcodes in between must hold
		for (int i = 0; i < numEntries; i++) begin
			makeInstr(i, v);
			apply(v);
			applyUnknown();
		end

		// Random stream with a reset in the middle
		for (int n = 0; n < numRandom; n++) begin
			randomBits(8, r);
			idx = r[7:3] % numEntries;
			if (r[2:0] == 3'b000 && n != numRandom / 2) begin
				applyUnknown();
			end else begin
				makeInstr(idx, v);
				apply(v);
			end
			if (n == numRandom / 2) begin
				rst = 1'b1;  // Valid instruction still applied
				@(posedge clk);
				#1 rst = 1'b0;
				@(negedge clk);
				assert (controlWord == 0 && constant == 0 && flag == 0 && length == 0)
					else reportError("outputs during reset", 64'(controlWord), 64'd0);
			end
		end

		applyUnknown();
		@(negedge clk);
		@(negedge clk);
		$display("Errors: %0d", errCount);
		if (errCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog sized from the instruction count
	initial begin
		#((numInstr + 20) * 10);
		$display("Run timed out before all instructions were applied");
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== verilog/controlPkg.sv ====
package controlPkg;

	//////////////////////////////////////////////////////////////////////
	// Basic widths
	//////////////////////////////////////////////////////////////////////

	localparam int regAddrWidth = 5;   // Register number, X0..X31
	localparam int opcodeWidth = 11;   // Instruction bits 31:21
	localparam int psWidth = 2;        // PC state field
	localparam int fsWidth = 5;        // ALU function select field

	// Sequential fetch, PC plus four
	localparam logic [psWidth-1:0] psIncrement = 2'b01;

	//////////////////////////////////////////////////////////////////////
	// Instruction classes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		aluReg,             // Register operand ALU ops
		aluImm,             // 12-bit immediate ALU ops
		load,               // LDUR family
		store,              // STUR family
		condBranchZero,     // CBZ
		condBranchNonZero,  // CBNZ
		condBranchFlags,    // B.cond, condition code in Rd
		branch,             // B
		branchLink,         // BL, writes the link register
		branchReg           // BR
	} instrClassT;

	//////////////////////////////////////////////////////////////////////
	// ALU function select codes
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [fsWidth-1:0] {
		aluAdd   = 5'b00010,
		aluSub   = 5'b00110,
		aluAnd   = 5'b01100,
		aluOrr   = 5'b01101,
		aluEor   = 5'b01110,
		aluLsl   = 5'b01111,
		aluLsr   = 5'b10000,
		aluPassA = 5'b01001  // Pass Rn straight through, used by BR
	} aluFuncT;

	// Memory access length, one-hot above byte
	typedef enum logic [2:0] {
		sizeByte   = 3'b000,
		sizeHalf   = 3'b001,
		sizeWord   = 3'b010,
		sizeDouble = 3'b100
	} accessSizeT;

	//////////////////////////////////////////////////////////////////////
	// Control word layout
	//////////////////////////////////////////////////////////////////////

	typedef logic [31:0] controlWordT;

	// Low bit of each multi-bit field
	localparam int psPos = 30;  // 31:30
	localparam int daPos = 25;  // 29:25 destination
	localparam int saPos = 20;  // 24:20 source A
	localparam int sbPos = 15;  // 19:15 source B
	localparam int fsPos = 10;  // 14:10 function select

	// Single bit strobes and selects
	localparam int regW  = 9;   // Register file write
	localparam int ramW  = 8;   // Data memory write
	localparam int enMem = 7;   // Memory drives the data bus
	localparam int enAlu = 6;   // ALU drives the data bus
	localparam int enB   = 5;   // B operand drives the data bus
	localparam int enPc  = 4;   // PC drives the data bus
	localparam int selB  = 3;   // B operand from constant
	localparam int pcSel = 2;   // Branch target mux
	localparam int sl    = 1;
	localparam int carry = 0;   // ALU carry in

endpackage

// ==== verilog/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit import controlPkg::*; #(
	parameter int DataWidth = 64  // Constant output width
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [31:0]          instruction,
	output controlWordT          controlWord,
	output logic [DataWidth-1:0] constant,
	output logic                 flag,
	output accessSizeT           length
);

	// Decode results, same cycle as the instruction
	instrClassT instrClass;
	aluFuncT    aluFunc;
	logic       setFlags;
	accessSizeT accessSize;
	logic       known;

	//////////////////////////////////////////////////////////////////////
	// Decode, then two register stages in parallel
	//////////////////////////////////////////////////////////////////////

	opcodeDecoder decoder (
		.opcode     (instruction[31:21]),
		.instrClass (instrClass),
		.aluFunc    (aluFunc),
		.setFlags   (setFlags),
		.accessSize (accessSize),
		.known      (known)
	);

	immediateGen #(
		.DataWidth (DataWidth)
	) immGen (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.instrClass  (instrClass),
		.known       (known),
		.constant    (constant)
	);

	controlWordBuilder wordBuilder (
		.clk         (clk),
		.rst         (rst),
		.instruction (instruction),
		.instrClass  (instrClass),
		.aluFunc     (aluFunc),
		.setFlags    (setFlags),
		.accessSize  (accessSize),
		.known       (known),
		.controlWord (controlWord),
		.flag        (flag),
		.length      (length)
	);

endmodule

// ==== verilog/controlWordBuilder.sv ====
`timescale 1ns/100ps

module controlWordBuilder import controlPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] instruction,
	input  instrClassT  instrClass,
	input  aluFuncT     aluFunc,
	input  logic        setFlags,
	input  accessSizeT  accessSize,
	input  logic        known,
	output controlWordT controlWord,
	output logic        flag,
	output accessSizeT  length
);

	logic [regAddrWidth-1:0] rd;
	logic [regAddrWidth-1:0] rn;
	logic [regAddrWidth-1:0] rm;
	controlWordT             nextWord;

	// Register numbers straight from the encoding
	assign rd = instruction[4:0];   // Also the condition code of B.cond
	assign rn = instruction[9:5];
	assign rm = instruction[20:16];

	//////////////////////////////////////////////////////////////////////
	// Word assembly
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextWord = '0;
		nextWord[psPos +: psWidth] = psIncrement;  // Every class steps the PC the same way
		nextWord[fsPos +: fsWidth] = aluFunc;
		nextWord[sl] = 1'b1;
		nextWord[enB] = 1'b0;    // B bus and PC bus drivers unused here
		nextWord[enPc] = 1'b0;
		nextWord[carry] = 1'b0;
		case (instrClass)
			aluReg, branchReg: begin
				nextWord[daPos +: regAddrWidth] = rd;
				nextWord[saPos +: regAddrWidth] = rn;
				nextWord[sbPos +: regAddrWidth] = rm;
				nextWord[regW] = (instrClass == aluReg);  // BR writes nothing
				nextWord[enAlu] = 1'b1;
			end
			aluImm: begin
				nextWord[daPos +: regAddrWidth] = rd;
				nextWord[saPos +: regAddrWidth] = rn;
				nextWord[regW] = 1'b1;
				nextWord[enAlu] = 1'b1;
				nextWord[selB] = 1'b1;  // Constant in place of Rm
			end
			load: begin
				nextWord[daPos +: regAddrWidth] = rd;
				nextWord[saPos +: regAddrWidth] = rn;
				nextWord[regW] = 1'b1;
				nextWord[enMem] = 1'b1;  // Memory data onto the bus
				nextWord[selB] = 1'b1;
			end
			store: begin
				nextWord[daPos +: regAddrWidth] = rd;  // Rt, the data register
				nextWord[saPos +: regAddrWidth] = rn;
				nextWord[ramW] = 1'b1;
				nextWord[enAlu] = 1'b1;
				nextWord[selB] = 1'b1;
			end
			condBranchZero, condBranchNonZero, condBranchFlags: begin
				nextWord[daPos +: regAddrWidth] = rd;
				nextWord[enAlu] = 1'b1;
				nextWord[pcSel] = 1'b1;
			end
			default: begin  // B and BL
				nextWord[regW] = (instrClass == branchLink);  // Link into X30
				nextWord[enAlu] = 1'b1;
				nextWord[pcSel] = 1'b1;
			end
		endcase
	end

	// Output registers, unknown opcodes leave them alone
	always_ff @(posedge clk) begin
		if (rst) begin
			controlWord <= '0;
			flag <= 1'b0;
			length <= sizeByte;  // All zero
		end else if (known) begin
			controlWord <= nextWord;
			flag <= setFlags;
			length <= accessSize;  // Decoder reports word outside loads and stores
		end
	end

endmodule

// ==== verilog/immediateGen.sv ====
`timescale 1ns/100ps

module immediateGen import controlPkg::*; #(
	parameter int DataWidth = 64
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [31:0]          instruction,
	input  instrClassT           instrClass,
	input  logic                 known,
	output logic [DataWidth-1:0] constant
);

	logic [DataWidth-1:0] nextConstant;

	//////////////////////////////////////////////////////////////////////
	// Field select and extend
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		nextConstant = constant;  // Classes without a constant keep the old one
		case (instrClass)
			aluImm:
				nextConstant = DataWidth'(instruction[21:10]);  // 12-bit ALU immediate
			load, store:
				nextConstant = DataWidth'(instruction[20:12]);  // 9-bit address offset
			condBranchZero, condBranchNonZero, condBranchFlags:
				// Word offset to byte offset
				nextConstant = DataWidth'({instruction[23:5], 2'b00});
			branch, branchLink:
				nextConstant = DataWidth'({instruction[25:0], 2'b00});
			default:
				nextConstant = constant;  // aluReg and BR
		endcase
	end

	// Output register
	always_ff @(posedge clk) begin
		if (rst) begin
			constant <= '0;
		end else if (known) begin
			constant <= nextConstant;
		end
	end

endmodule

// ==== verilog/opcodeDecoder.sv ====
`timescale 1ns/100ps

module opcodeDecoder import controlPkg::*; (
	input  logic [opcodeWidth-1:0] opcode,      // Instruction bits 31:21
	output instrClassT             instrClass,
	output aluFuncT                aluFunc,
	output logic                   setFlags,
	output accessSizeT             accessSize,
	output logic                   known        // Some rule matched
);

	//////////////////////////////////////////////////////////////////////
	// Group helpers
	//////////////////////////////////////////////////////////////////////

	// Arithmetic ops, bit 30 of the instruction picks subtract
	function automatic aluFuncT arithFunc(input logic isSub);
		return isSub ? aluSub : aluAdd;
	endfunction

	// Logical ops, opc field in instruction bits 30:29
	function automatic aluFuncT logicFunc(input logic [1:0] opc);
		aluFuncT func;
		case (opc)
			2'b01:   func = aluOrr;
			2'b10:   func = aluEor;
			default: func = aluAnd;  // AND and ANDS
		endcase
		return func;
	endfunction

	// Transfer size from instruction bits 31:30
	function automatic accessSizeT sizeFunc(input logic [1:0] size);
		accessSizeT len;
		case (size)
			2'b00:   len = sizeByte;
			2'b01:   len = sizeHalf;
			2'b10:   len = sizeWord;
			default: len = sizeDouble;
		endcase
		return len;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Opcode match
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		instrClass = aluReg;
		aluFunc = aluAdd;
		setFlags = 1'b0;
		accessSize = sizeWord;  // Non-memory ops report a word
		known = 1'b1;
		priority casez (opcode)
			11'b1??01011000: begin  // ADD SUB ADDS SUBS
				aluFunc = arithFunc(opcode[9]);
				setFlags = opcode[8];  // S bit
			end
			11'b1??01010000: begin  // AND ORR EOR ANDS
				aluFunc = logicFunc(opcode[9:8]);
				setFlags = &opcode[9:8];
			end
			11'b1101001101?: begin  // LSR LSL
				aluFunc = opcode[0] ? aluLsl : aluLsr;
			end
			11'b1??1000100?: begin  // ADDI SUBI ADDIS SUBIS
				instrClass = aluImm;
				aluFunc = arithFunc(opcode[9]);
				setFlags = opcode[8];
			end
			11'b1??1001000?: begin  // ANDI ORRI EORI ANDIS
				instrClass = aluImm;
				aluFunc = logicFunc(opcode[9:8]);
				setFlags = &opcode[9:8];
			end
			11'b??111000010: begin  // LDUR at all four sizes
				instrClass = load;
				accessSize = sizeFunc(opcode[10:9]);
			end
			11'b??111000000: begin  // STUR at all four sizes
				instrClass = store;
				accessSize = sizeFunc(opcode[10:9]);
			end
			// Conditional branches test through the AND path
			11'b10110100???: begin
				instrClass = condBranchZero;
				aluFunc = aluAnd;
			end
			11'b10110101???: begin
				instrClass = condBranchNonZero;
				aluFunc = aluAnd;
			end
			11'b01010100???: begin
				instrClass = condBranchFlags;
				aluFunc = aluAnd;
			end
			11'b000101?????: begin  // B, 26-bit offset
				instrClass = branch;
				aluFunc = aluAnd;
			end
			11'b100101?????: begin  // BL
				instrClass = branchLink;
				aluFunc = aluAnd;
			end
			11'b11010110000: begin  // BR, target from Rn
				instrClass = branchReg;
				aluFunc = aluPassA;
			end
			default: known = 1'b0;  // Downstream registers hold
		endcase
	end

endmodule

// ==== vlog.f ====
+incdir+test
verilog/controlPkg.sv
verilog/opcodeDecoder.sv
verilog/immediateGen.sv
verilog/controlWordBuilder.sv
verilog/controlUnit.sv
test/tbControlUnit.sv
